// File: Bender.yml
package:
  name: dma8237lite

sources:
  - include_dirs:
      - include
    files:
      - logic/dmaPkg.sv
      - logic/dmaRegisters.sv
      - logic/dmaPriority.sv
      - logic/dmaTiming.sv
      - logic/dmaTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/dma_props.sv
      - verif/dmaTb.sv

// File: flist.f
+incdir+include
logic/dmaPkg.sv
logic/dmaRegisters.sv
logic/dmaPriority.sv
logic/dmaTiming.sv
logic/dmaTop.sv
verif/dma_props.sv
verif/dmaTb.sv

// File: include/dma_config.svh
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// number of DMA channels
`define DMA_CHANNELS 4

// transfer address and word count widths
`define DMA_ADDR_W 16
`define DMA_COUNT_W 16

// register map offsets on the CPU bus
// offsets 0 to 7 hold the channel address and count pairs
`define DMA_REG_CMD 4'd8
`define DMA_REG_MODE 4'd11
`define DMA_REG_CLRFF 4'd12
`define DMA_REG_MCLR 4'd13

`endif

// File: logic/dmaPkg.sv
`include "dma_config.svh"

package dmaPkg;

  // CPU programming bus, strobes are active low
  typedef struct packed {
    logic       csN;
    logic       iorN;
    logic       iowN;
    logic [3:0] addr;
    logic [7:0] wrData;
  } cpuBus_t;

  // system bus outputs while the controller owns the bus
  typedef struct packed {
    logic [`DMA_ADDR_W-1:0] addr;
    logic                   aen;
    logic                   adstb;
    logic                   memrN;
    logic                   memwN;
    logic                   ioReadN;
    logic                   ioWriteN;
    logic                   eopN;
  } xferBus_t;

  // timing states, SI SO S1 S2 S4 in 8237 terms
  typedef enum logic [2:0] {
    stIdle     = 3'd0,
    stHoldWait = 3'd1,
    stAddr     = 3'd2,
    stRead     = 3'd3,
    stWrite    = 3'd4
  } dmaState_t;

  // transfer field of the mode register
  typedef enum logic [1:0] {
    xferVerify = 2'd0,
    xferWrite  = 2'd1,
    xferRead   = 2'd2
  } xferType_t;

  // per channel mode
  typedef struct packed {
    xferType_t xferType;
    logic      autoInit;
    logic      addrDecrement;
  } modeReg_t;

endpackage

// File: logic/dmaPriority.sv
`timescale 1ns/1ns
`include "dma_config.svh"

module dmaPriority (
  input  logic                     busIf,
  input  logic                     rstN,
  input  logic [`DMA_CHANNELS-1:0] reqMasked,
  input  logic                     rotate,
  input  logic                     serviceDone,
  output logic [`DMA_CHANNELS-1:0] grant
);

  // entry 0 is the highest priority channel
  localparam logic [`DMA_CHANNELS-1:0][1:0] DefaultOrder = {2'd3, 2'd2, 2'd1, 2'd0};

  logic [`DMA_CHANNELS-1:0][1:0] prioOrder;
  logic [`DMA_CHANNELS-1:0][1:0] effOrder;
  logic [1:0]                    servedChan;

  // fixed mode ignores the stored order
  assign effOrder = rotate ? prioOrder : DefaultOrder;

  // scan lowest to highest, so the highest request wins
  always_comb
  begin
    grant = '0;
    for (int i = `DMA_CHANNELS - 1; i >= 0; i--)
    begin
      if (reqMasked[effOrder[i]])
      begin
        grant = '0;
        grant[effOrder[i]] = 1'b1;
      end
    end
  end

  // index of the granted channel
  always_comb
  begin
    servedChan = '0;
    for (int i = 0; i < `DMA_CHANNELS; i++)
      if (grant[i])
        servedChan = 2'(i);
  end

  // requests are levels held through service, so the grant in S4
  // is still the channel being served
  always_ff @(posedge busIf)
  begin
    if (!rstN || !rotate)
      prioOrder <= DefaultOrder;
    else if (serviceDone && |grant)
    begin
      // served channel drops to the bottom
      for (int i = 0; i < `DMA_CHANNELS; i++)
        prioOrder[i] <= servedChan + 2'(i) + 2'd1;
    end
  end

endmodule

// File: logic/dmaRegisters.sv
`timescale 1ns/1ns
`include "dma_config.svh"

module dmaRegisters
  import dmaPkg::*;
(
  input  logic                     busIf,
  input  logic                     rstN,
  input  cpuBus_t                  cpu,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  input  logic [1:0]               activeChan,
  input  logic                     stepChan,
  output logic [7:0]               rdData,
  output logic [`DMA_CHANNELS-1:0] reqMasked,
  output logic                     enabled,
  output logic                     rotate,
  output logic [`DMA_ADDR_W-1:0]   chanAddr,
  output modeReg_t                 chanMode,
  output logic                     terminalCount
);

  // programmable state
  logic [7:0]               cmdReg;
  modeReg_t                 modeReg [`DMA_CHANNELS];
  logic [`DMA_ADDR_W-1:0]   baseAddr [`DMA_CHANNELS];
  logic [`DMA_ADDR_W-1:0]   curAddr [`DMA_CHANNELS];
  logic [`DMA_COUNT_W-1:0]  baseCount [`DMA_CHANNELS];
  logic [`DMA_COUNT_W-1:0]  curCount [`DMA_CHANNELS];
  logic                     byteFf;
  logic [`DMA_CHANNELS-1:0] mask;
  logic [`DMA_CHANNELS-1:0] tcFlag;

  // access decode
  logic                     wrAcc;
  logic                     rdAcc;
  logic                     chanSel;
  logic                     cntSel;
  logic [1:0]               regChan;
  logic [1:0]               modeChan;
  logic                     masterClr;
  logic [`DMA_ADDR_W-1:0]   rdWord;
  logic [7:0]               rdNext;

  // replace the byte picked by the byte pointer
  function automatic logic [15:0] putByte(logic [15:0] word, logic hiSel, logic [7:0] data);
    putByte = hiSel ? {data, word[7:0]} : {word[15:8], data};
  endfunction

  // a write wins if both strobes are low
  assign wrAcc = !cpu.csN && !cpu.iowN;
  assign rdAcc = !cpu.csN && !cpu.iorN && cpu.iowN;
  // offsets 0..7 are channel address/count pairs
  assign chanSel = !cpu.addr[3];
  assign cntSel = cpu.addr[0];
  assign regChan = cpu.addr[2:1];
  assign modeChan = cpu.wrData[1:0];
  assign masterClr = wrAcc && (cpu.addr == `DMA_REG_MCLR);

  // current register of the addressed channel
  assign rdWord = cntSel ? curCount[regChan] : curAddr[regChan];

  always_comb
  begin
    rdNext = 8'h00;
    if (chanSel)
      rdNext = byteFf ? rdWord[15:8] : rdWord[7:0];
    else if (cpu.addr == `DMA_REG_CMD)
      // status, live requests over TC flags
      rdNext = {dreq, tcFlag};
  end

  always_ff @(posedge busIf)
  begin
    if (!rstN || masterClr)
    begin
      cmdReg <= '0;
      byteFf <= 1'b0;
      mask <= '0;
      tcFlag <= '0;
      rdData <= '0;
      for (int i = 0; i < `DMA_CHANNELS; i++)
      begin
        modeReg[i] <= '0;
        baseAddr[i] <= '0;
        curAddr[i] <= '0;
        baseCount[i] <= '0;
        curCount[i] <= '0;
      end
    end
    else
    begin
      // CPU read, data held until next read
      if (rdAcc)
      begin
        rdData <= rdNext;
        if (chanSel)
          byteFf <= !byteFf;
        if (cpu.addr == `DMA_REG_CMD)
          tcFlag <= '0;
      end

      // step after S4, sets TC on top of a status clear
      if (stepChan)
      begin
        curAddr[activeChan] <= chanMode.addrDecrement ? chanAddr - 1'b1 : chanAddr + 1'b1;
        curCount[activeChan] <= curCount[activeChan] - 1'b1;
        if (terminalCount)
        begin
          tcFlag[activeChan] <= 1'b1;
          if (chanMode.autoInit)
          begin
            curAddr[activeChan] <= baseAddr[activeChan];
            curCount[activeChan] <= baseCount[activeChan];
          end
          else
            mask[activeChan] <= 1'b1;
        end
      end

      // CPU write, base and current load together
      if (wrAcc)
      begin
        if (chanSel)
        begin
          byteFf <= !byteFf;
          if (cntSel)
          begin
            baseCount[regChan] <= putByte(baseCount[regChan], byteFf, cpu.wrData);
            curCount[regChan] <= putByte(curCount[regChan], byteFf, cpu.wrData);
          end
          else
          begin
            baseAddr[regChan] <= putByte(baseAddr[regChan], byteFf, cpu.wrData);
            curAddr[regChan] <= putByte(curAddr[regChan], byteFf, cpu.wrData);
          end
        end
        else
        begin
          case (cpu.addr)
            `DMA_REG_CMD:
              cmdReg <= cpu.wrData;
            `DMA_REG_MODE:
            begin
              modeReg[modeChan] <= '{xferType: xferType_t'(cpu.wrData[3:2]),
                                     autoInit: cpu.wrData[4],
                                     addrDecrement: cpu.wrData[5]};
              // mode write re-arms the channel
              mask[modeChan] <= 1'b0;
            end
            `DMA_REG_CLRFF:
              byteFf <= 1'b0;
            default:
              cmdReg <= cmdReg;
          endcase
        end
      end
    end
  end

  // outputs toward priority and timing
  assign reqMasked = dreq & ~mask;
  assign enabled = !cmdReg[2];
  assign rotate = cmdReg[4];
  assign chanAddr = curAddr[activeChan];
  assign chanMode = modeReg[activeChan];
  assign terminalCount = (curCount[activeChan] == '0);

endmodule

// File: logic/dmaTiming.sv
`timescale 1ns/1ns
`include "dma_config.svh"

module dmaTiming
  import dmaPkg::*;
(
  input  logic                     busIf,
  input  logic                     rstN,
  input  logic [`DMA_CHANNELS-1:0] grant,
  input  logic                     enabled,
  input  logic                     hlda,
  input  logic [`DMA_ADDR_W-1:0]   chanAddr,
  input  modeReg_t                 chanMode,
  input  logic                     terminalCount,
  output logic                     hrq,
  output logic [`DMA_CHANNELS-1:0] dack,
  output logic [1:0]               activeChan,
  output logic                     stepChan,
  output logic                     serviceDone,
  output xferBus_t                 xfer
);

  dmaState_t  state;
  dmaState_t  stateNext;
  logic [1:0] grantChan;
  logic       svcPulse;

  // one-hot grant to channel number
  always_comb
  begin
    grantChan = '0;
    for (int i = 0; i < `DMA_CHANNELS; i++)
      if (grant[i])
        grantChan = 2'(i);
  end

  always_comb
  begin
    stateNext = state;
    case (state)
      stIdle:
        if (enabled && |grant)
          stateNext = stHoldWait;
      // wait here as long as the CPU keeps the bus
      stHoldWait:
        if (hlda)
          stateNext = stAddr;
      stAddr:
        stateNext = stRead;
      stRead:
        stateNext = stWrite;
      default:
        stateNext = stIdle;
    endcase
  end

  always_ff @(posedge busIf)
  begin
    if (!rstN)
    begin
      state <= stIdle;
      activeChan <= '0;
    end
    else
    begin
      state <= stateNext;
      // winner is frozen for the whole service
      if (state == stIdle && stateNext == stHoldWait)
        activeChan <= grantChan;
    end
  end

  // single S4 pulse, steps registers and rotates priority
  assign svcPulse = (state == stWrite);
  assign stepChan = svcPulse;
  assign serviceDone = svcPulse;

  // hold request spans SO through S4
  assign hrq = (state != stIdle);

  always_comb
  begin
    dack = '0;
    if (state == stRead || state == stWrite)
      dack[activeChan] = 1'b1;
  end

  // bus strobes by state and transfer type
  always_comb
  begin
    xfer = '{addr: '0, aen: 1'b0, adstb: 1'b0, memrN: 1'b1, memwN: 1'b1,
             ioReadN: 1'b1, ioWriteN: 1'b1, eopN: 1'b1};
    case (state)
      stAddr:
      begin
        xfer.addr = chanAddr;
        xfer.aen = 1'b1;
        // latch pulse for the upper address byte
        xfer.adstb = 1'b1;
      end
      stRead:
      begin
        xfer.addr = chanAddr;
        xfer.aen = 1'b1;
        if (chanMode.xferType == xferRead)
          xfer.memrN = 1'b0;
        else if (chanMode.xferType == xferWrite)
          xfer.ioReadN = 1'b0;
      end
      stWrite:
      begin
        xfer.addr = chanAddr;
        if (chanMode.xferType == xferRead)
        begin
          xfer.memrN = 1'b0;
          xfer.ioWriteN = 1'b0;
        end
        else if (chanMode.xferType == xferWrite)
        begin
          xfer.ioReadN = 1'b0;
          xfer.memwN = 1'b0;
        end
        // end of process on the last word
        xfer.eopN = !terminalCount;
      end
      default:
        xfer.addr = '0;
    endcase
  end

endmodule

// File: logic/dmaTop.sv
`timescale 1ns/1ns
`include "dma_config.svh"

module dmaTop
  import dmaPkg::*;
(
  input  logic                     busIf,
  input  logic                     rstN,
  input  cpuBus_t                  cpu,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  input  logic                     hlda,
  output logic [7:0]               rdData,
  output logic                     hrq,
  output logic [`DMA_CHANNELS-1:0] dack,
  output xferBus_t                 xfer
);

  // register file to priority and timing
  logic [`DMA_CHANNELS-1:0] reqMasked;
  logic                     enabled;
  logic                     rotate;
  logic [`DMA_ADDR_W-1:0]   chanAddr;
  modeReg_t                 chanMode;
  logic                     terminalCount;
  // priority to timing
  logic [`DMA_CHANNELS-1:0] grant;
  // timing back to registers and priority
  logic [1:0]               activeChan;
  logic                     stepChan;
  logic                     serviceDone;

  dmaRegisters regs (
    .busIf         (busIf),
    .rstN          (rstN),
    .cpu           (cpu),
    .dreq          (dreq),
    .activeChan    (activeChan),
    .stepChan      (stepChan),
    .rdData        (rdData),
    .reqMasked     (reqMasked),
    .enabled       (enabled),
    .rotate        (rotate),
    .chanAddr      (chanAddr),
    .chanMode      (chanMode),
    .terminalCount (terminalCount)
  );

  dmaPriority prio (
    .busIf       (busIf),
    .rstN        (rstN),
    .reqMasked   (reqMasked),
    .rotate      (rotate),
    .serviceDone (serviceDone),
    .grant       (grant)
  );

  dmaTiming timing (
    .busIf         (busIf),
    .rstN          (rstN),
    .grant         (grant),
    .enabled       (enabled),
    .hlda          (hlda),
    .chanAddr      (chanAddr),
    .chanMode      (chanMode),
    .terminalCount (terminalCount),
    .hrq           (hrq),
    .dack          (dack),
    .activeChan    (activeChan),
    .stepChan      (stepChan),
    .serviceDone   (serviceDone),
    .xfer          (xfer)
  );

endmodule

// File: verif/dmaTb.sv
`timescale 1ns/1ns
`include "dma_config.svh"

module dmaTb
  import dmaPkg::*;
();

  localparam int WaitLimit = 40;

  logic                     busIf;
  logic                     rstN;
  cpuBus_t                  cpu;
  logic [`DMA_CHANNELS-1:0] dreq;
  logic                     hlda;
  logic [7:0]               rdData;
  logic                     hrq;
  logic [`DMA_CHANNELS-1:0] dack;
  xferBus_t                 xfer;

  int valueErrors;
  int timeoutErrors;
  int holdCnt;
  integer seed;

  dmaTop uut (
    .busIf  (busIf),
    .rstN   (rstN),
    .cpu    (cpu),
    .dreq   (dreq),
    .hlda   (hlda),
    .rdData (rdData),
    .hrq    (hrq),
    .dack   (dack),
    .xfer   (xfer)
  );

  // 8 ns period
  always #4 busIf = ~busIf;

  // CPU side raises hold acknowledge 1 to 4 cycles after hrq
  always @(negedge busIf)
  begin
    if (!rstN || !hrq)
    begin
      hlda = 1'b0;
      holdCnt = 0;
    end
    else if (!hlda)
    begin
      if (holdCnt == 0)
        holdCnt = 1 + ($unsigned($random(seed)) % 4);
      holdCnt = holdCnt - 1;
      if (holdCnt == 0)
        hlda = 1'b1;
    end
  end

  task automatic checkByte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
    begin
      valueErrors++;
      $display("FAIL %s: expected %02h, actual %02h", name, exp, act);
    end
  endtask

  task automatic checkDack(input string name, input logic [`DMA_CHANNELS-1:0] exp,
                           input logic [`DMA_CHANNELS-1:0] act);
    if (act !== exp)
    begin
      valueErrors++;
      $display("FAIL %s: expected dack %b, actual %b", name, exp, act);
    end
  endtask

  // control bits shown as aen adstb memrN memwN ioReadN ioWriteN eopN
  task automatic checkXfer(input string name, input xferBus_t exp, input xferBus_t act);
    if (act !== exp)
    begin
      valueErrors++;
      $display("FAIL %s: expected addr %04h ctl %b, actual addr %04h ctl %b",
               name, exp.addr, exp[6:0], act.addr, act[6:0]);
    end
  endtask

  // expected bus values in phase 0 (S1), 1 (S2) and 2 (S4)
  function automatic xferBus_t expXfer(input int phase, input xferType_t kind,
                                       input logic [15:0] addr, input logic lastWord);
    xferBus_t e;
    e.addr = addr;
    e.aen = (phase < 2);
    e.adstb = (phase == 0);
    e.memrN = 1'b1;
    e.memwN = 1'b1;
    e.ioReadN = 1'b1;
    e.ioWriteN = 1'b1;
    e.eopN = 1'b1;
    if (kind == xferRead)
    begin
      e.memrN = (phase == 0);
      e.ioWriteN = (phase != 2);
    end
    else if (kind == xferWrite)
    begin
      e.ioReadN = (phase == 0);
      e.memwN = (phase != 2);
    end
    // eop marks the last word in S4
    if (phase == 2)
      e.eopN = !lastWord;
    return e;
  endfunction

  // all bus tasks start and end on a falling edge
  task automatic cpuWrite(input logic [3:0] offset, input logic [7:0] data);
    cpu.csN = 1'b0;
    cpu.iowN = 1'b0;
    cpu.addr = offset;
    cpu.wrData = data;
    @(negedge busIf);
    cpu.csN = 1'b1;
    cpu.iowN = 1'b1;
  endtask

  task automatic cpuRead(input logic [3:0] offset, output logic [7:0] data);
    cpu.csN = 1'b0;
    cpu.iorN = 1'b0;
    cpu.addr = offset;
    @(negedge busIf);
    cpu.csN = 1'b1;
    cpu.iorN = 1'b1;
    // registered read data is ready after the access edge
    data = rdData;
  endtask

  task automatic readAndCheck(input string name, input logic [3:0] offset,
                              input logic [7:0] exp);
    logic [7:0] data;
    cpuRead(offset, data);
    checkByte(name, exp, data);
  endtask

  task automatic progChan(input logic [1:0] chan, input logic [15:0] addr,
                          input logic [15:0] count, input xferType_t kind,
                          input logic autoInit, input logic dec);
    cpuWrite(`DMA_REG_CLRFF, 8'h00);
    cpuWrite({1'b0, chan, 1'b0}, addr[7:0]);
    cpuWrite({1'b0, chan, 1'b0}, addr[15:8]);
    cpuWrite({1'b0, chan, 1'b1}, count[7:0]);
    cpuWrite({1'b0, chan, 1'b1}, count[15:8]);
    cpuWrite(`DMA_REG_MODE, {2'b00, dec, autoInit, kind, chan});
  endtask

  // every channel verify with autoinit so none gets masked
  task automatic armAll();
    int ch;
    for (ch = 0; ch < `DMA_CHANNELS; ch++)
      cpuWrite(`DMA_REG_MODE, {4'b0001, xferVerify, 2'(ch)});
  endtask

  task automatic waitHrqLow(input string name);
    int n;
    n = 0;
    do
    begin
      @(negedge busIf);
      n++;
    end while (hrq && n < WaitLimit);
    if (hrq)
    begin
      timeoutErrors++;
      $display("TIMEOUT in %s: hrq never fell", name);
    end
  endtask

  // one full service from hrq through S4 checked per phase
  task automatic serveAndCheck(input string name, input xferType_t kind,
                               input logic [15:0] addr, input logic lastWord,
                               input logic [`DMA_CHANNELS-1:0] expDack);
    int n;
    int phase;
    n = 0;
    do
    begin
      @(negedge busIf);
      n++;
    end while (!hrq && n < WaitLimit);
    if (!hrq)
    begin
      timeoutErrors++;
      $display("TIMEOUT in %s: hrq never rose", name);
      return;
    end
    n = 0;
    while (!xfer.adstb && n < WaitLimit)
    begin
      @(negedge busIf);
      n++;
    end
    if (!xfer.adstb)
    begin
      timeoutErrors++;
      $display("TIMEOUT in %s: no address strobe after hold acknowledge", name);
      return;
    end
    for (phase = 0; phase < 3; phase++)
    begin
      if (phase > 0)
        @(negedge busIf);
      checkXfer($sformatf("%s phase %0d", name, phase), expXfer(phase, kind, addr, lastWord),
                xfer);
      checkDack($sformatf("%s phase %0d", name, phase), (phase == 0) ? '0 : expDack, dack);
    end
  endtask

  task automatic testRegisters();
    readAndCheck("reset status", `DMA_REG_CMD, 8'h00);
    progChan(2'd1, 16'h1234, 16'h0305, xferVerify, 1'b0, 1'b0);
    readAndCheck("ch1 addr lo", 4'd2, 8'h34);
    readAndCheck("ch1 addr hi", 4'd2, 8'h12);
    readAndCheck("ch1 count lo", 4'd3, 8'h05);
    readAndCheck("ch1 count hi", 4'd3, 8'h03);
    // pointer left on the high byte and then cleared
    readAndCheck("ch1 addr lo again", 4'd2, 8'h34);
    cpuWrite(`DMA_REG_CLRFF, 8'h00);
    readAndCheck("ch1 addr after clear", 4'd2, 8'h34);
    readAndCheck("ch1 addr hi after clear", 4'd2, 8'h12);
  endtask

  task automatic testReadXfer();
    cpuWrite(`DMA_REG_MCLR, 8'h00);
    progChan(2'd0, 16'h1000, 16'h0005, xferRead, 1'b0, 1'b0);
    dreq = 4'b0001;
    serveAndCheck("read first", xferRead, 16'h1000, 1'b0, 4'b0001);
    serveAndCheck("read second", xferRead, 16'h1001, 1'b0, 4'b0001);
    dreq = '0;
    waitHrqLow("read xfer");
  endtask

  task automatic testFixedPriority();
    int pat;
    logic [3:0] lowest;
    cpuWrite(`DMA_REG_MCLR, 8'h00);
    armAll();
    for (pat = 1; pat < 16; pat++)
    begin
      lowest = 4'(pat) & (~4'(pat) + 4'd1);
      dreq = 4'(pat);
      serveAndCheck($sformatf("fixed dreq %b", 4'(pat)), xferVerify, 16'h0000, 1'b1, lowest);
      dreq = '0;
      waitHrqLow("fixed priority");
    end
  endtask

  task automatic testRotatePriority();
    int k;
    cpuWrite(`DMA_REG_MCLR, 8'h00);
    armAll();
    cpuWrite(`DMA_REG_CMD, 8'h10);
    dreq = 4'b1111;
    for (k = 0; k < 4; k++)
      serveAndCheck($sformatf("rotate turn %0d", k), xferVerify, 16'h0000, 1'b1, 4'(1 << k));
    dreq = '0;
    waitHrqLow("rotate priority");
    cpuWrite(`DMA_REG_CMD, 8'h00);
  endtask

  task automatic testTerminalCount();
    int n;
    logic [`DMA_CHANNELS-1:0] seen;
    cpuWrite(`DMA_REG_MCLR, 8'h00);
    progChan(2'd2, 16'h2000, 16'h0002, xferRead, 1'b0, 1'b0);
    dreq = 4'b0100;
    serveAndCheck("tc word 0", xferRead, 16'h2000, 1'b0, 4'b0100);
    serveAndCheck("tc word 1", xferRead, 16'h2001, 1'b0, 4'b0100);
    serveAndCheck("tc word 2", xferRead, 16'h2002, 1'b1, 4'b0100);
    dreq = '0;
    waitHrqLow("terminal count");
    readAndCheck("tc status", `DMA_REG_CMD, 8'h04);
    readAndCheck("tc status cleared", `DMA_REG_CMD, 8'h00);
    // masked channel must stay quiet
    seen = '0;
    dreq = 4'b0100;
    for (n = 0; n < 20; n++)
    begin
      @(negedge busIf);
      seen = seen | dack;
    end
    checkDack("masked after tc", 4'b0000, seen);
    // masked request still shows as live in the status
    readAndCheck("tc live request", `DMA_REG_CMD, 8'h40);
    dreq = '0;
    // autoinit reloads the base address after the last word
    progChan(2'd2, 16'h2000, 16'h0001, xferRead, 1'b1, 1'b0);
    dreq = 4'b0100;
    serveAndCheck("auto word 0", xferRead, 16'h2000, 1'b0, 4'b0100);
    serveAndCheck("auto word 1", xferRead, 16'h2001, 1'b1, 4'b0100);
    serveAndCheck("auto reload", xferRead, 16'h2000, 1'b0, 4'b0100);
    dreq = '0;
    waitHrqLow("autoinit");
    readAndCheck("auto status", `DMA_REG_CMD, 8'h04);
  endtask

  task automatic testWriteVerify();
    cpuWrite(`DMA_REG_MCLR, 8'h00);
    progChan(2'd3, 16'h3005, 16'h0003, xferWrite, 1'b0, 1'b1);
    dreq = 4'b1000;
    serveAndCheck("write dec 0", xferWrite, 16'h3005, 1'b0, 4'b1000);
    serveAndCheck("write dec 1", xferWrite, 16'h3004, 1'b0, 4'b1000);
    dreq = '0;
    waitHrqLow("write xfer");
    // switch to verify while the address keeps counting down
    cpuWrite(`DMA_REG_MODE, {2'b00, 1'b1, 1'b0, xferVerify, 2'd3});
    dreq = 4'b1000;
    serveAndCheck("verify dec", xferVerify, 16'h3003, 1'b0, 4'b1000);
    dreq = '0;
    waitHrqLow("verify xfer");
  endtask

  initial
  begin
    seed = 33451;
    valueErrors = 0;
    timeoutErrors = 0;
    holdCnt = 0;
    busIf = 1'b0;
    rstN = 1'b0;
    hlda = 1'b0;
    dreq = '0;
    cpu.csN = 1'b1;
    cpu.iorN = 1'b1;
    cpu.iowN = 1'b1;
    cpu.addr = '0;
    cpu.wrData = '0;
    repeat (10) @(negedge busIf);
    rstN = 1'b1;
    @(negedge busIf);

    testRegisters();
    testReadXfer();
    testFixedPriority();
    testRotatePriority();
    testTerminalCount();
    testWriteVerify();

    $display("errors: %0d value mismatches, %0d timeouts", valueErrors, timeoutErrors);
    if (valueErrors == 0 && timeoutErrors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: verif/dma_props.sv
`timescale 1ns/1ns
`include "dma_config.svh"

module dmaProps
  import dmaPkg::*;
(
  input logic                     busIf,
  input logic                     rstN,
  input logic                     hrq,
  input logic [`DMA_CHANNELS-1:0] dack,
  input xferBus_t                 xfer
);

  // at most one channel acknowledged
  dackOneHot: assert property (@(posedge busIf) disable iff (!rstN)
    $onehot0(dack))
    else $error("dack has more than one bit set");

  // io read and io write never overlap
  ioStrobeExclusive: assert property (@(posedge busIf) disable iff (!rstN)
    !(!xfer.ioReadN && !xfer.ioWriteN))
    else $error("ioReadN and ioWriteN both low");

  // address strobe only in S1
  adstbOneCycle: assert property (@(posedge busIf) disable iff (!rstN)
    $rose(xfer.adstb) |=> !xfer.adstb)
    else $error("adstb longer than one cycle");

  // aen covers S1 and S2
  aenTwoCycles: assert property (@(posedge busIf) disable iff (!rstN)
    $rose(xfer.aen) |=> xfer.aen ##1 !xfer.aen)
    else $error("aen not exactly two cycles");

  // bus released only once the acknowledge is gone
  hrqAfterDack: assert property (@(posedge busIf) disable iff (!rstN)
    $fell(hrq) |-> (dack == '0))
    else $error("hrq fell while dack still high");

endmodule

bind dmaTop dmaProps props (
  .busIf (busIf),
  .rstN  (rstN),
  .hrq   (hrq),
  .dack  (dack),
  .xfer  (xfer)
);
